/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_apb
RTL_TOP   ?= axi_apb_top
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ns -j 0
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= all tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

/* include/axi_define.svh */
`ifndef AXI_DEFINE_SVH
`define AXI_DEFINE_SVH

// Response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

// Burst types
`define AXI_BURST_FIXED 2'b00
`define AXI_BURST_INCR  2'b01
`define AXI_BURST_WRAP  2'b10

`endif

/* rtl/apb_mem_slave.sv */
`timescale 1ns/1ns

module apb_mem_slave #(
    parameter int MEM_WORDS   = 64,
    parameter int WAIT_CYCLES = 1
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               psel,
    input  logic               penable,
    input  apb_pkg::apb_req_t  req,
    output apb_pkg::apb_rsp_t  rsp,
    output logic               pready
);

    import apb_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

    apb_data_t        mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic [CNT_W-1:0] wait_cnt;
    logic             access;

    assign idx      = req.addr[IDX_W+1:2];
    assign in_range = (req.addr[31:2] < 30'(MEM_WORDS));
    assign access   = psel & penable;

    // Wait states inside the access phase
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wait_cnt <= '0;
        end else if (access && pready) begin
            wait_cnt <= '0;
        end else if (access) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign pready = (wait_cnt == CNT_W'(WAIT_CYCLES));

    always_ff @(posedge aclk) begin
        if (access && pready && req.write && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strb[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign rsp.rdata  = in_range ? mem[idx] : '0;
    assign rsp.slverr = ~in_range;  // Word beyond depth

endmodule

/* rtl/apb_pkg.sv */
package apb_pkg;

    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [3:0]  apb_strb_t;

    // Driven by the bridge, qualified by psel/penable
    typedef struct packed {
        apb_addr_t  addr;
        logic       write;
        apb_data_t  wdata;
        apb_strb_t  strb;
        logic [2:0] prot;  // Always zero
    } apb_req_t;

    typedef struct packed {
        apb_data_t rdata;
        logic      slverr;
    } apb_rsp_t;

endpackage

/* rtl/axi_apb_top.sv */
`timescale 1ns/1ns

module axi_apb_top #(
    parameter int MEM_WORDS   = 64,
    parameter int WAIT_CYCLES = 1
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  axi_pkg::axi_ax_t  aw,
    input  logic              awvalid,
    output logic              awready,
    input  axi_pkg::axi_w_t   w,
    input  logic              wvalid,
    output logic              wready,
    output axi_pkg::axi_b_t   b,
    output logic              bvalid,
    input  logic              bready,
    input  axi_pkg::axi_ax_t  ar,
    input  logic              arvalid,
    output logic              arready,
    output axi_pkg::axi_r_t   r,
    output logic              rvalid,
    input  logic              rready
);

    import axi_pkg::*;
    import apb_pkg::*;

    logic      load, is_read, beat_done, capture_rdata, resp_clear;
    logic      last_beat;
    logic      psel, penable, pready, pwrite;
    axi_ax_t   cmd;
    axi_addr_t addr;
    axi_id_t   id;
    axi_resp_t resp;
    axi_data_t rdata;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;

    assign cmd = is_read ? ar : aw;

    // wstrb goes straight to pstrb
    assign apb_req.addr  = addr;
    assign apb_req.write = pwrite;
    assign apb_req.wdata = w.data;
    assign apb_req.strb  = w.strb;
    assign apb_req.prot  = 3'b000;

    assign b.id   = id;
    assign b.resp = resp;
    assign r.id   = id;
    assign r.data = rdata;
    assign r.resp = resp;
    assign r.last = last_beat;

    bridge_fsm i_fsm (
        .aclk(aclk), .aresetn(aresetn),
        .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rready(rready), .last_beat(last_beat),
        .psel(psel), .penable(penable), .pready(pready), .pwrite(pwrite),
        .load(load), .is_read(is_read), .beat_done(beat_done),
        .capture_rdata(capture_rdata), .resp_clear(resp_clear)
    );

    burst_addr_gen i_addr_gen (
        .aclk(aclk), .aresetn(aresetn), .load(load), .beat_done(beat_done),
        .cmd(cmd), .addr(addr), .last_beat(last_beat)
    );

    bridge_datapath i_datapath (
        .aclk(aclk), .aresetn(aresetn), .load(load), .is_read(is_read),
        .capture_rdata(capture_rdata), .resp_clear(resp_clear),
        .aw_id(aw.id), .ar_id(ar.id), .psel(psel), .pready(pready),
        .apb_rsp(apb_rsp), .penable(penable), .id(id), .resp(resp), .rdata(rdata)
    );

    apb_mem_slave #(
        .MEM_WORDS(MEM_WORDS),
        .WAIT_CYCLES(WAIT_CYCLES)
    ) i_mem (
        .aclk(aclk), .aresetn(aresetn), .psel(psel), .penable(penable),
        .req(apb_req), .rsp(apb_rsp), .pready(pready)
    );

endmodule

/* rtl/axi_pkg.sv */
package axi_pkg;

    typedef logic [3:0]  axi_id_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [7:0]  axi_len_t;   // Beats minus one
    typedef logic [2:0]  axi_size_t;  // log2 bytes per beat
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    // Address channel, same layout for AW and AR
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

endpackage

/* rtl/bridge_datapath.sv */
`timescale 1ns/1ns
`include "axi_define.svh"

module bridge_datapath (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                load,
    input  logic                is_read,
    input  logic                capture_rdata,
    input  logic                resp_clear,
    input  axi_pkg::axi_id_t    aw_id,
    input  axi_pkg::axi_id_t    ar_id,
    input  logic                psel,
    input  logic                pready,
    input  apb_pkg::apb_rsp_t   apb_rsp,
    output logic                penable,
    output axi_pkg::axi_id_t    id,
    output axi_pkg::axi_resp_t  resp,
    output axi_pkg::axi_data_t  rdata
);

    logic apb_done;

    assign apb_done = psel & penable & pready;

    // Access phase follows setup, drops on completion
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            penable <= 1'b0;
        end else begin
            penable <= psel & ~apb_done;
        end
    end

    // Sticky over a write burst, per beat on reads
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            resp <= `AXI_RESP_OKAY;
        end else if (apb_done && apb_rsp.slverr) begin
            resp <= `AXI_RESP_SLVERR;
        end else if (resp_clear) begin
            resp <= `AXI_RESP_OKAY;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            id <= is_read ? ar_id : aw_id;
        end
    end

    always_ff @(posedge aclk) begin
        if (capture_rdata) begin
            rdata <= apb_rsp.rdata;
        end
    end

endmodule

/* rtl/bridge_fsm.sv */
`timescale 1ns/1ns

module bridge_fsm (
    input  logic aclk,
    input  logic aresetn,
    input  logic awvalid,
    output logic awready,
    input  logic wvalid,
    output logic wready,
    output logic bvalid,
    input  logic bready,
    input  logic arvalid,
    output logic arready,
    output logic rvalid,
    input  logic rready,
    input  logic last_beat,
    output logic psel,
    input  logic penable,
    input  logic pready,
    output logic pwrite,
    output logic load,
    output logic is_read,
    output logic beat_done,
    output logic capture_rdata,
    output logic resp_clear
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        WRITE_RESP,
        READ,
        READ_RESP
    } bridge_state_t;

    bridge_state_t state;
    bridge_state_t state_nxt;
    logic          apb_done;

    assign apb_done = psel & penable & pready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (arvalid) begin  // Reads win a tie
                    state_nxt = READ;
                end else if (awvalid) begin
                    state_nxt = WRITE;
                end
            end
            WRITE: begin
                if (apb_done && last_beat) begin
                    state_nxt = WRITE_RESP;
                end
            end
            WRITE_RESP: begin
                if (bready) begin
                    state_nxt = IDLE;
                end
            end
            READ: begin
                if (apb_done) begin
                    state_nxt = READ_RESP;
                end
            end
            READ_RESP: begin
                if (rready) begin
                    state_nxt = last_beat ? IDLE : READ;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Handshakes
    assign arready = (state == IDLE);
    assign awready = (state == IDLE) & ~arvalid;
    assign load    = (state == IDLE) & (arvalid | awvalid);
    assign wready  = (state == WRITE) & apb_done;  // W stalls on the APB target
    assign bvalid  = (state == WRITE_RESP);
    assign rvalid  = (state == READ_RESP);

    // In IDLE this tells which command is being taken
    assign is_read = (state == IDLE) ? arvalid : (state == READ) | (state == READ_RESP);

    assign psel    = (state == READ) | ((state == WRITE) & wvalid);
    assign pwrite  = (state == WRITE);

    assign capture_rdata = (state == READ) & apb_done;
    assign beat_done     = wready | (rvalid & rready);
    assign resp_clear    = (bvalid & bready) | (rvalid & rready);

    // Transfer stays selected until the target completes it
    a_psel_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        psel && !(penable && pready) |=> psel);

    // Burst position frozen while a response waits
    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid && !bready |=> bvalid && $stable(last_beat));

    a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(last_beat));

endmodule

/* rtl/burst_addr_gen.sv */
`timescale 1ns/1ns
`include "axi_define.svh"

module burst_addr_gen (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                load,
    input  logic                beat_done,
    input  axi_pkg::axi_ax_t    cmd,
    output axi_pkg::axi_addr_t  addr,
    output logic                last_beat
);

    import axi_pkg::*;

    axi_addr_t addr_mask;  // Ones mark bits held across beats
    axi_addr_t wrap_span;
    axi_size_t size_q;
    axi_len_t  cnt;
    logic      active;

    // Bytes covered by one wrap block
    assign wrap_span = (axi_addr_t'(cmd.len) + 32'd1) << cmd.size;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cnt    <= '0;
            active <= 1'b0;
        end else if (load) begin
            cnt    <= cmd.len;
            active <= 1'b1;
        end else if (beat_done) begin
            if (cnt == '0) begin
                active <= 1'b0;
            end else begin
                cnt <= cnt - 8'd1;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            addr      <= '0;
            addr_mask <= '0;
            size_q    <= '0;
        end else if (load) begin
            addr   <= cmd.addr;
            size_q <= cmd.size;
            case (cmd.burst)
                `AXI_BURST_FIXED: addr_mask <= '1;
                `AXI_BURST_WRAP:  addr_mask <= ~(wrap_span - 32'd1);
                default:          addr_mask <= '0;  // INCR
            endcase
        end else if (beat_done) begin
            addr <= (addr & addr_mask) | ((addr + (32'd1 << size_q)) & ~addr_mask);
        end
    end

    assign last_beat = (cnt == '0);

    // No beats after the final one until a new command loads
    a_no_extra_beat: assert property (@(posedge aclk) disable iff (!aresetn)
        beat_done |-> active);

endmodule

/* sources.f */
+incdir+include
rtl/axi_pkg.sv
rtl/apb_pkg.sv
rtl/bridge_fsm.sv
rtl/burst_addr_gen.sv
rtl/bridge_datapath.sv
rtl/apb_mem_slave.sv
rtl/axi_apb_top.sv
verif/tb_axi_apb.sv

/* verif/tb_axi_apb.sv */
`timescale 1ns/1ns
`include "axi_define.svh"

module tb_axi_apb;

    import axi_pkg::*;

    localparam int MEM_WORDS   = 64;
    localparam int WAIT_CYCLES = 1;
    localparam int MAX_CYCLES  = 4000;  // 6 tests x 16 beats x ~12 cycles, with margin

    logic      aclk;
    logic      aresetn;
    logic      awvalid, awready, wvalid, wready, bvalid, bready;
    logic      arvalid, arready, rvalid, rready;
    axi_ax_t   aw;
    axi_ax_t   ar;
    axi_w_t    w;
    axi_b_t    b;
    axi_r_t    r;
    integer    seed;
    int        cycle_cnt = 0;
    int        failed_tests = 0;
    int        test_errs;
    int        read_end;
    int        write_end;
    string     test_name;
    axi_data_t ref_mem [int];  // Expected words by word index
    axi_data_t wbuf [16];

    axi_apb_top #(.MEM_WORDS(MEM_WORDS), .WAIT_CYCLES(WAIT_CYCLES)) i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // Byte address of one beat, from the AXI burst rules
    function automatic axi_addr_t beat_addr(axi_addr_t start, axi_len_t len, axi_size_t size,
                                            axi_burst_t burst, int beat);
        int unsigned bytes;
        int unsigned total;
        int unsigned base;
        bytes = 1 << size;
        total = bytes * (int'(len) + 1);
        base  = (start / total) * total;  // Wrap block start
        case (burst)
            `AXI_BURST_FIXED: return start;
            `AXI_BURST_WRAP:  return base + ((start - base + beat * bytes) % total);
            default:          return start + beat * bytes;
        endcase
    endfunction

    function automatic void model_write(axi_addr_t a, axi_data_t data, axi_strb_t strb);
        int        widx;
        axi_data_t word;
        widx = int'(a >> 2);
        if (widx < MEM_WORDS) begin
            word = ref_mem.exists(widx) ? ref_mem[widx] : '0;
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) word[8*i +: 8] = data[8*i +: 8];
            end
            ref_mem[widx] = word;
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch in %s: %s expected 0x%08h, actual 0x%08h",
                     test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_len_t len, input axi_size_t size,
                             input axi_burst_t burst, input axi_data_t data [16],
                             input axi_id_t id);
        axi_resp_t exp_resp;
        axi_addr_t a;
        logic      done;
        exp_resp = `AXI_RESP_OKAY;
        @(posedge aclk);
        aw      <= '{id: id, addr: addr, len: len, size: size, burst: burst};
        awvalid <= 1'b1;
        do @(negedge aclk); while (!awready);
        @(posedge aclk);
        awvalid <= 1'b0;
        for (int k = 0; k <= int'(len); k++) begin
            w      <= '{data: data[k], strb: 4'hF, last: (k == int'(len))};
            wvalid <= 1'b1;
            do @(negedge aclk); while (!wready);
            a = beat_addr(addr, len, size, burst, k);
            if (int'(a >> 2) >= MEM_WORDS) exp_resp = `AXI_RESP_SLVERR;
            model_write(a, data[k], 4'hF);
            @(posedge aclk);
        end
        wvalid <= 1'b0;
        do begin
            bready <= ($random(seed) % 3) != 0;  // Random B stalls
            @(negedge aclk);
            done = bvalid && bready;
            if (!done) @(posedge aclk);
        end while (!done);
        write_end = cycle_cnt;
        check_value("bid", 32'(id), 32'(b.id));
        check_value("bresp", 32'(exp_resp), 32'(b.resp));
        @(posedge aclk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, input axi_len_t len, input axi_size_t size,
                            input axi_burst_t burst, input axi_id_t id);
        int        widx;
        axi_data_t exp_data;
        axi_resp_t exp_resp;
        logic      done;
        @(posedge aclk);
        ar      <= '{id: id, addr: addr, len: len, size: size, burst: burst};
        arvalid <= 1'b1;
        do @(negedge aclk); while (!arready);
        @(posedge aclk);
        arvalid <= 1'b0;
        for (int k = 0; k <= int'(len); k++) begin
            do begin
                rready <= ($random(seed) % 3) != 0;
                @(negedge aclk);
                done = rvalid && rready;
                if (!done) @(posedge aclk);
            end while (!done);
            widx     = int'(beat_addr(addr, len, size, burst, k) >> 2);
            exp_resp = (widx >= MEM_WORDS) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
            exp_data = (widx < MEM_WORDS && ref_mem.exists(widx)) ? ref_mem[widx] : '0;
            check_value($sformatf("rdata beat %0d", k), exp_data, r.data);
            check_value($sformatf("rresp beat %0d", k), 32'(exp_resp), 32'(r.resp));
            check_value("rid", 32'(id), 32'(r.id));
            if (k == int'(len)) begin
                assert (r.last) else begin
                    $display("%s: rlast missing on the final beat %0d", test_name, k);
                    test_errs++;
                end
            end else begin
                assert (!r.last) else begin
                    $display("%s: early rlast on beat %0d of %0d", test_name, k, int'(len) + 1);
                    test_errs++;
                end
            end
            @(posedge aclk);
        end
        rready   <= 1'b0;
        read_end = cycle_cnt;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: FAIL with %0d errors", test_name, test_errs);
            failed_tests++;
        end
    endtask

    task automatic single_beat_access();
        start_test("single_beat");
        wbuf[0] = 32'hDEAD_BEEF;
        axi_write(32'h0000_0004, 8'd0, 3'd2, `AXI_BURST_INCR, wbuf, 4'd1);
        axi_read(32'h0000_0004, 8'd0, 3'd2, `AXI_BURST_INCR, 4'd2);
        report_test();
    endtask

    task automatic incr_burst();
        start_test("incr_burst");
        for (int k = 0; k < 4; k++) wbuf[k] = 32'h1100_0000 | 32'(k);
        axi_write(32'h0000_0010, 8'd3, 3'd2, `AXI_BURST_INCR, wbuf, 4'd3);
        axi_read(32'h0000_0010, 8'd3, 3'd2, `AXI_BURST_INCR, 4'd3);
        report_test();
    endtask

    task automatic wrap_burst();
        start_test("wrap_burst");
        for (int k = 0; k < 8; k++) wbuf[k] = 32'h3300_0000 | 32'(k);
        axi_write(32'h0000_0050, 8'd7, 3'd2, `AXI_BURST_WRAP, wbuf, 4'd7);  // Mid-block start
        axi_read(32'h0000_0040, 8'd7, 3'd2, `AXI_BURST_INCR, 4'd8);
        report_test();
    endtask

    task automatic fixed_burst();
        start_test("fixed_burst");
        for (int k = 0; k < 4; k++) wbuf[k] = 32'h4400_0000 | 32'(k);
        axi_write(32'h0000_0080, 8'd3, 3'd2, `AXI_BURST_FIXED, wbuf, 4'd4);
        axi_read(32'h0000_0080, 8'd0, 3'd2, `AXI_BURST_INCR, 4'd4);
        report_test();
    endtask

    task automatic out_of_range();
        start_test("out_of_range");
        for (int k = 0; k < 4; k++) wbuf[k] = 32'h5500_0000 | 32'(k);
        // Words 62 and 63 exist, 64 and 65 do not
        axi_write(32'h0000_00F8, 8'd3, 3'd2, `AXI_BURST_INCR, wbuf, 4'd5);
        axi_read(32'h0000_00F8, 8'd3, 3'd2, `AXI_BURST_INCR, 4'd10);
        // Word 1 shares index bits with word 65
        axi_read(32'h0000_0004, 8'd0, 3'd2, `AXI_BURST_INCR, 4'd12);
        report_test();
    endtask

    task automatic back_pressure();
        start_test("back_pressure");
        for (int k = 0; k < 8; k++) wbuf[k] = $random(seed);
        fork
            axi_write(32'h0000_00A0, 8'd7, 3'd2, `AXI_BURST_INCR, wbuf, 4'd6);
            axi_read(32'h0000_0010, 8'd3, 3'd2, `AXI_BURST_INCR, 4'd9);
        join
        assert (write_end > read_end) else begin
            $display("%s: write response arrived before the read burst finished", test_name);
            test_errs++;
        end
        axi_read(32'h0000_00A0, 8'd7, 3'd2, `AXI_BURST_INCR, 4'd11);
        report_test();
    endtask

    initial begin
        seed    = 14;
        aresetn <= 1'b0;
        aw      <= '0;
        awvalid <= 1'b0;
        w       <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        ar      <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;
        single_beat_access();
        incr_burst();
        wrap_burst();
        fixed_burst();
        out_of_range();
        back_pressure();
        $display("Summary: 6 tests run, %0d with errors", failed_tests);
        if (failed_tests == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
